// File: files.f
+incdir+rtl
rtl/mlkem_arith_pkg.sv
rtl/masked_share_pkg.sv
rtl/share_delay_line.sv
rtl/masked_add_sub.sv
rtl/masked_mod_mult.sv
rtl/bfly_ctrl.sv
rtl/masked_gs_butterfly.sv
tb/tb_masked_gs_butterfly.sv

// File: rtl/bfly_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Butterfly stage enables, output strobe and busy flag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mlkem_params.svh"

module bfly_ctrl (
    input logic clk,
    input logic reset_n,
    input logic zeroize_i,
    input logic valid_i,
    // Bit k loads the register k stages from the input
    output logic [`BFLY_LAT-1:0] stage_en_o,
    output logic valid_o,
    output logic busy_o
);

    // Bit k set when stage k holds a real item
    logic [`BFLY_LAT-1:0] vld_q;

    always_ff @(posedge clk) begin
        if (!reset_n || zeroize_i) begin
            // Items in flight are dropped
            vld_q <= '0;
        end
        else begin
            vld_q <= {vld_q[`BFLY_LAT-2:0], valid_i};
        end
    end

    // Stage 0 loads with the input strobe
    // Later stages load when their source stage is valid
    assign stage_en_o = {vld_q[`BFLY_LAT-2:0], valid_i};

    // Last stage feeds the outputs directly
    assign valid_o = vld_q[`BFLY_LAT-1];

    // Any occupied stage
    assign busy_o = |vld_q;

    // Zeroize clears the pipeline within one cycle
    assert property (@(posedge clk) disable iff (!reset_n)
        zeroize_i |=> (!valid_o && !busy_o))
        else $error("bfly_ctrl strobe seen right after zeroize");

endmodule

// File: rtl/masked_add_sub.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-stage masked modular adder or subtractor with refresh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mlkem_params.svh"

module masked_add_sub #(
    // 0 gives a + b, 1 gives a - b
    parameter bit SUBTRACT = 1'b0
) (
    input logic clk,
    input logic reset_n,
    input logic zeroize_i,
    input logic [`ADD_SUB_LAT-1:0] en_i,
    input masked_share_pkg::masked_coeff_t op_a_i,
    input masked_share_pkg::masked_coeff_t op_b_i,
    input mlkem_arith_pkg::coeff_t rnd_i,
    output masked_share_pkg::masked_coeff_t res_o
);

    // Share-wise result before refresh
    masked_share_pkg::masked_coeff_t s1_d;
    masked_share_pkg::masked_coeff_t s1_q;
    // Random word travels with stage 1
    mlkem_arith_pkg::coeff_t rnd_q;
    // Refreshed result
    masked_share_pkg::masked_coeff_t s2_d;
    masked_share_pkg::masked_coeff_t s2_q;

    // Stage 1 shares never mix
    always_comb begin
        if (SUBTRACT) begin
            s1_d.share0 = mlkem_arith_pkg::mod_sub(op_a_i.share0, op_b_i.share0);
            s1_d.share1 = mlkem_arith_pkg::mod_sub(op_a_i.share1, op_b_i.share1);
        end
        else begin
            s1_d.share0 = mlkem_arith_pkg::mod_add(op_a_i.share0, op_b_i.share0);
            s1_d.share1 = mlkem_arith_pkg::mod_add(op_a_i.share1, op_b_i.share1);
        end
    end

    // Stage 2 moves r from one share to the other
    // Sum of shares is unchanged
    always_comb begin
        s2_d.share0 = mlkem_arith_pkg::mod_add(s1_q.share0, rnd_q);
        s2_d.share1 = mlkem_arith_pkg::mod_sub(s1_q.share1, rnd_q);
    end

    always_ff @(posedge clk) begin
        if (!reset_n || zeroize_i) begin
            s1_q <= '0;
            rnd_q <= '0;
            s2_q <= '0;
        end
        else begin
            if (en_i[0]) begin
                s1_q <= s1_d;
                rnd_q <= rnd_i;
            end
            if (en_i[1]) begin
                s2_q <= s2_d;
            end
        end
    end

    assign res_o = s2_q;

    // Out of range mask word would break the mod q refresh
    assert property (@(posedge clk) disable iff (!reset_n)
        en_i[1] |-> (rnd_q < `MLKEM_Q))
        else $error("masked_add_sub random word not below q");

endmodule

// File: rtl/masked_gs_butterfly.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Masked Gentleman-Sande butterfly for the ML-KEM inverse NTT
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mlkem_params.svh"

module masked_gs_butterfly (
    input logic clk,
    input logic reset_n,
    input logic zeroize_i,
    input logic valid_i,
    input masked_share_pkg::masked_coeff_t opu_i,
    input masked_share_pkg::masked_coeff_t opv_i,
    input masked_share_pkg::masked_coeff_t opw_i,
    input masked_share_pkg::rnd_bundle_t rnd_i,
    output logic valid_o,
    output logic busy_o,
    // u + v
    output masked_share_pkg::masked_coeff_t u_o,
    // (u - v) * w
    output masked_share_pkg::masked_coeff_t v_o
);

    logic [`BFLY_LAT-1:0] stage_en;
    masked_share_pkg::masked_coeff_t add_res;
    masked_share_pkg::masked_coeff_t sub_res;
    // w and r_mul aligned with the difference
    masked_share_pkg::masked_coeff_t w_dly;
    mlkem_arith_pkg::coeff_t rmul_dly;

    bfly_ctrl u_ctrl (
        .clk(clk),
        .reset_n(reset_n),
        .zeroize_i(zeroize_i),
        .valid_i(valid_i),
        .stage_en_o(stage_en),
        .valid_o(valid_o),
        .busy_o(busy_o)
    );

    // Sum path
    masked_add_sub #(
        .SUBTRACT(1'b0)
    ) u_add (
        .clk(clk),
        .reset_n(reset_n),
        .zeroize_i(zeroize_i),
        .en_i(stage_en[`ADD_SUB_LAT-1:0]),
        .op_a_i(opu_i),
        .op_b_i(opv_i),
        .rnd_i(rnd_i.r_add),
        .res_o(add_res)
    );

    // Difference path
    masked_add_sub #(
        .SUBTRACT(1'b1)
    ) u_sub (
        .clk(clk),
        .reset_n(reset_n),
        .zeroize_i(zeroize_i),
        .en_i(stage_en[`ADD_SUB_LAT-1:0]),
        .op_a_i(opu_i),
        .op_b_i(opv_i),
        .rnd_i(rnd_i.r_sub),
        .res_o(sub_res)
    );

    // Sum waits out the multiplier
    share_delay_line #(
        .payload_t(masked_share_pkg::masked_coeff_t),
        .DEPTH(`MULT_LAT)
    ) u_u_dly (
        .clk(clk),
        .reset_n(reset_n),
        .zeroize_i(zeroize_i),
        .en_i(stage_en[`BFLY_LAT-1:`ADD_SUB_LAT]),
        .data_i(add_res),
        .data_o(u_o)
    );

    // Twiddle waits out the subtractor
    share_delay_line #(
        .payload_t(masked_share_pkg::masked_coeff_t),
        .DEPTH(`ADD_SUB_LAT)
    ) u_w_dly (
        .clk(clk),
        .reset_n(reset_n),
        .zeroize_i(zeroize_i),
        .en_i(stage_en[`ADD_SUB_LAT-1:0]),
        .data_i(opw_i),
        .data_o(w_dly)
    );

    share_delay_line #(
        .payload_t(mlkem_arith_pkg::coeff_t),
        .DEPTH(`ADD_SUB_LAT)
    ) u_rmul_dly (
        .clk(clk),
        .reset_n(reset_n),
        .zeroize_i(zeroize_i),
        .en_i(stage_en[`ADD_SUB_LAT-1:0]),
        .data_i(rnd_i.r_mul),
        .data_o(rmul_dly)
    );

    masked_mod_mult u_mult (
        .clk(clk),
        .reset_n(reset_n),
        .zeroize_i(zeroize_i),
        .en_i(stage_en[`BFLY_LAT-1:`ADD_SUB_LAT]),
        .op_a_i(sub_res),
        .op_b_i(w_dly),
        .rnd_i(rmul_dly),
        .res_o(v_o)
    );

endmodule

// File: rtl/masked_mod_mult.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Three-stage masked modular multiplier with Barrett reduction
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mlkem_params.svh"

module masked_mod_mult (
    input logic clk,
    input logic reset_n,
    input logic zeroize_i,
    input logic [`MULT_LAT-1:0] en_i,
    input masked_share_pkg::masked_coeff_t op_a_i,
    input masked_share_pkg::masked_coeff_t op_b_i,
    input mlkem_arith_pkg::coeff_t rnd_i,
    output masked_share_pkg::masked_coeff_t res_o
);

    // Cross products a0b0, a0b1, a1b0, a1b1
    mlkem_arith_pkg::prod_t [3:0] prod_q;
    mlkem_arith_pkg::coeff_t rnd_s1_q;
    // Barrett intermediates
    mlkem_arith_pkg::barrett_t [3:0] bar_full;
    mlkem_arith_pkg::coeff_t [3:0] quot;
    mlkem_arith_pkg::coeff_sum_t [3:0] rem;
    mlkem_arith_pkg::coeff_t [3:0] red_d;
    // Reduced products
    mlkem_arith_pkg::coeff_t [3:0] red_q;
    mlkem_arith_pkg::coeff_t rnd_s2_q;
    // Output shares
    masked_share_pkg::masked_coeff_t res_d;
    masked_share_pkg::masked_coeff_t res_q;

    // Barrett reduction of each product
    // Inputs below q^2 leave a remainder below 2q
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            bar_full[i] = mlkem_arith_pkg::barrett_t'(prod_q[i])
                          * mlkem_arith_pkg::barrett_t'(`MLKEM_BARRETT_M);
            quot[i] = mlkem_arith_pkg::coeff_t'(bar_full[i] >> `MLKEM_BARRETT_SHIFT);
            rem[i] = mlkem_arith_pkg::coeff_sum_t'(prod_q[i]
                     - mlkem_arith_pkg::prod_t'(quot[i]) * mlkem_arith_pkg::prod_t'(`MLKEM_Q));
            // Single correction step
            red_d[i] = (rem[i] >= `MLKEM_Q) ? mlkem_arith_pkg::coeff_t'(rem[i] - `MLKEM_Q)
                                             : mlkem_arith_pkg::coeff_t'(rem[i]);
        end
    end

    // Share 0 collects a0 terms, share 1 collects a1 terms
    // r_mul added on one side and removed on the other
    always_comb begin
        res_d.share0 = mlkem_arith_pkg::mod_add(
            mlkem_arith_pkg::mod_add(red_q[0], red_q[1]), rnd_s2_q);
        res_d.share1 = mlkem_arith_pkg::mod_sub(
            mlkem_arith_pkg::mod_add(red_q[2], red_q[3]), rnd_s2_q);
    end

    always_ff @(posedge clk) begin
        if (!reset_n || zeroize_i) begin
            prod_q <= '0;
            rnd_s1_q <= '0;
            red_q <= '0;
            rnd_s2_q <= '0;
            res_q <= '0;
        end
        else begin
            // Stage 1 raw cross products
            if (en_i[0]) begin
                prod_q[0] <= mlkem_arith_pkg::prod_t'(op_a_i.share0) * op_b_i.share0;
                prod_q[1] <= mlkem_arith_pkg::prod_t'(op_a_i.share0) * op_b_i.share1;
                prod_q[2] <= mlkem_arith_pkg::prod_t'(op_a_i.share1) * op_b_i.share0;
                prod_q[3] <= mlkem_arith_pkg::prod_t'(op_a_i.share1) * op_b_i.share1;
                rnd_s1_q <= rnd_i;
            end
            // Stage 2 reduced mod q
            if (en_i[1]) begin
                red_q <= red_d;
                rnd_s2_q <= rnd_s1_q;
            end
            // Stage 3 combined and refreshed
            if (en_i[2]) begin
                res_q <= res_d;
            end
        end
    end

    assign res_o = res_q;

    // Each reduced product entering the combine stage is fully reduced
    for (genvar i = 0; i < 4; i++) begin : g_red_chk
        assert property (@(posedge clk) disable iff (!reset_n)
            en_i[2] |-> (red_q[i] < `MLKEM_Q))
            else $error("masked_mod_mult reduced product %0d not below q", i);
    end

endmodule

// File: rtl/masked_share_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Masked share pair and random word bundle types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package masked_share_pkg;

    // Arithmetic masking of one coefficient
    // True value is (share0 + share1) mod q
    typedef struct packed {
        mlkem_arith_pkg::coeff_t share1;
        mlkem_arith_pkg::coeff_t share0;
    } masked_coeff_t;

    // Fresh randomness for one butterfly
    // Every word must be below q
    typedef struct packed {
        // Refresh of the multiplier output
        mlkem_arith_pkg::coeff_t r_mul;
        // Refresh of the difference
        mlkem_arith_pkg::coeff_t r_sub;
        // Refresh of the sum
        mlkem_arith_pkg::coeff_t r_add;
    } rnd_bundle_t;

    // Share order inside both structs is low word first
    // so share0 and r_add sit in the low bits

endpackage

// File: rtl/mlkem_arith_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Plain coefficient, product types and modular add/sub helpers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mlkem_params.svh"

package mlkem_arith_pkg;

    // One coefficient in [0, q)
    typedef logic [`MLKEM_COEFF_W-1:0] coeff_t;
    // Coefficient plus carry bit
    typedef logic [`MLKEM_COEFF_W:0] coeff_sum_t;
    // Unreduced product of two coefficients
    typedef logic [2*`MLKEM_COEFF_W-1:0] prod_t;
    // Product times Barrett multiplier
    typedef logic [3*`MLKEM_COEFF_W:0] barrett_t;

    // (a + b) mod q for a, b < q
    function automatic coeff_t mod_add(coeff_t a, coeff_t b);
        coeff_sum_t s;
        s = coeff_sum_t'(a) + coeff_sum_t'(b);
        if (s >= coeff_sum_t'(`MLKEM_Q)) begin
            s = s - coeff_sum_t'(`MLKEM_Q);
        end
        return coeff_t'(s);
    endfunction

    // (a - b) mod q for a, b < q
    function automatic coeff_t mod_sub(coeff_t a, coeff_t b);
        coeff_sum_t s;
        // Borrow case folds q back in first
        s = (a < b) ? coeff_sum_t'(a) + coeff_sum_t'(`MLKEM_Q) : coeff_sum_t'(a);
        s = s - coeff_sum_t'(b);
        return coeff_t'(s);
    endfunction

endpackage

// File: rtl/mlkem_params.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ML-KEM modulus, Barrett constants and butterfly stage latencies
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef MLKEM_PARAMS_SVH
`define MLKEM_PARAMS_SVH

// ML-KEM prime modulus
`define MLKEM_Q 12'd3329

// Coefficient width in bits
`define MLKEM_COEFF_W 12

// Barrett multiplier floor(2^24 / q)
`define MLKEM_BARRETT_M 13'd5039
// Barrett shift matching the multiplier above
`define MLKEM_BARRETT_SHIFT 24

// Add/sub unit latency in cycles
`define ADD_SUB_LAT 2
// Masked multiplier latency in cycles
`define MULT_LAT 3
// Full butterfly latency
`define BFLY_LAT (`ADD_SUB_LAT + `MULT_LAT)

`endif

// File: rtl/share_delay_line.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Enable-gated delay line for any payload type
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module share_delay_line #(
    parameter type payload_t = mlkem_arith_pkg::coeff_t,
    parameter int DEPTH = 2
) (
    input logic clk,
    input logic reset_n,
    input logic zeroize_i,
    // One enable per register
    input logic [DEPTH-1:0] en_i,
    input payload_t data_i,
    output payload_t data_o
);

    // Register chain, index 0 nearest the input
    payload_t stage_q [DEPTH];

    always_ff @(posedge clk) begin
        if (!reset_n || zeroize_i) begin
            // Wipe every stage including held shares
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end
        else begin
            // First stage loads from the port
            if (en_i[0]) begin
                stage_q[0] <= data_i;
            end
            // Later stages shift only with valid data
            for (int i = 1; i < DEPTH; i++) begin
                if (en_i[i]) begin
                    stage_q[i] <= stage_q[i-1];
                end
            end
        end
    end

    // Oldest entry
    assign data_o = stage_q[DEPTH-1];

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the masked butterfly testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f files.f --top-module tb_masked_gs_butterfly -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_masked_gs_butterfly 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
exit 1

// File: tb/tb_masked_gs_butterfly.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Masked GS butterfly testbench with random stimulus, share model,
// output monitor, watchdog and summary
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mlkem_params.svh"

module tb_masked_gs_butterfly;

    localparam int PERIOD = 4;
    localparam int Q = `MLKEM_Q;
    localparam int W = `MLKEM_COEFF_W;
    localparam int LAT = `BFLY_LAT;
    localparam int RESET_CYCLES = 8;
    localparam int N_SINGLE = 200;
    localparam int N_STREAM = 300;
    localparam int N_ZERO_PRE = 40;
    localparam int N_ZERO_POST = 40;
    localparam int DRAIN_LIMIT = LAT + 4;
    // Streams add up to 3 idle cycles after an item
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 4
        + N_SINGLE * (LAT + 2)
        + N_STREAM * 4
        + (N_ZERO_PRE + N_ZERO_POST) * 4 + 2 * LAT
        + 4 * DRAIN_LIMIT + 50;

    logic clk = 1'b0;
    logic reset_n;
    logic zeroize;
    logic valid_in;
    masked_share_pkg::masked_coeff_t opu;
    masked_share_pkg::masked_coeff_t opv;
    masked_share_pkg::masked_coeff_t opw;
    masked_share_pkg::rnd_bundle_t rnd;
    logic valid_out;
    logic busy;
    masked_share_pkg::masked_coeff_t u_out;
    masked_share_pkg::masked_coeff_t v_out;

    // Model queues with one entry per item in flight
    masked_share_pkg::masked_coeff_t exp_u_q[$];
    masked_share_pkg::masked_coeff_t exp_v_q[$];
    int true_u_q[$];
    int true_v_q[$];
    int issue_cyc_q[$];

    int cyc = 0;
    int checks = 0;
    int errors = 0;
    int tests = 0;
    int test_err_start;
    string cur_test = "reset";
    // Outputs must read zero while set
    bit zero_chk = 1'b0;

    masked_gs_butterfly u_dut (
        .clk(clk),
        .reset_n(reset_n),
        .zeroize_i(zeroize),
        .valid_i(valid_in),
        .opu_i(opu),
        .opv_i(opv),
        .opw_i(opw),
        .rnd_i(rnd),
        .valid_o(valid_out),
        .busy_o(busy),
        .u_o(u_out),
        .v_o(v_out)
    );

    always #(PERIOD / 2) clk = ~clk;

    // Cycle number read by drivers and monitor
    always @(posedge clk) cyc <= cyc + 1;

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_error(string msg);
        $display("ERROR in %s: %s", cur_test, msg);
        errors++;
    endtask

    function automatic int draw_coeff();
        return int'($urandom % Q);
    endfunction

    task automatic drop_oldest();
        void'(issue_cyc_q.pop_front());
        void'(exp_u_q.pop_front());
        void'(exp_v_q.pop_front());
        void'(true_u_q.pop_front());
        void'(true_v_q.pop_front());
    endtask

    task automatic flush_model();
        issue_cyc_q.delete();
        exp_u_q.delete();
        exp_v_q.delete();
        true_u_q.delete();
        true_v_q.delete();
    endtask

    // Drive one random butterfly and queue what the DUT must return
    task automatic issue_item();
        int u0, u1, v0, v1, w0, w1;
        int ra, rs, rm;
        int d0, d1;
        int tu, tv, tw;
        masked_share_pkg::masked_coeff_t eu;
        masked_share_pkg::masked_coeff_t ev;
        @(posedge clk);
        #1;
        u0 = draw_coeff();
        u1 = draw_coeff();
        v0 = draw_coeff();
        v1 = draw_coeff();
        w0 = draw_coeff();
        w1 = draw_coeff();
        ra = draw_coeff();
        rs = draw_coeff();
        rm = draw_coeff();
        opu.share0 = W'(u0);
        opu.share1 = W'(u1);
        opv.share0 = W'(v0);
        opv.share1 = W'(v1);
        opw.share0 = W'(w0);
        opw.share1 = W'(w1);
        rnd.r_add = W'(ra);
        rnd.r_sub = W'(rs);
        rnd.r_mul = W'(rm);
        valid_in = 1'b1;
        // Sum shares with r_add moved from share1 to share0
        eu.share0 = W'(((u0 + v0) % Q + ra) % Q);
        eu.share1 = W'(((u1 + v1) % Q - ra + Q) % Q);
        // Difference shares refreshed with r_sub
        d0 = ((u0 - v0 + Q) % Q + rs) % Q;
        d1 = ((u1 - v1 + Q) % Q - rs + Q) % Q;
        // Each difference share times the whole twiddle
        ev.share0 = W'(((d0 * w0 + d0 * w1) % Q + rm) % Q);
        ev.share1 = W'(((d1 * w0 + d1 * w1) % Q - rm + Q) % Q);
        // Unmasked values
        tu = (u0 + u1) % Q;
        tv = (v0 + v1) % Q;
        tw = (w0 + w1) % Q;
        issue_cyc_q.push_back(cyc);
        exp_u_q.push_back(eu);
        exp_v_q.push_back(ev);
        true_u_q.push_back((tu + tv) % Q);
        true_v_q.push_back(((tu - tv + Q) % Q * tw) % Q);
    endtask

    task automatic idle_cycles(int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            valid_in = 1'b0;
        end
    endtask

    // Wait for every queued item with a bounded number of cycles
    task automatic wait_drained();
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            #1;
            valid_in = 1'b0;
            waited++;
        end while (issue_cyc_q.size() > 0 && waited < DRAIN_LIMIT);
        if (issue_cyc_q.size() > 0) begin
            report_error($sformatf("%0d items still in flight after %0d cycles",
                                   issue_cyc_q.size(), DRAIN_LIMIT));
            flush_model();
        end
    endtask

    // One cycle of zeroize drops in-flight items
    task automatic apply_zeroize();
        @(posedge clk);
        #1;
        valid_in = 1'b0;
        zeroize = 1'b1;
        @(posedge clk);
        #1;
        zeroize = 1'b0;
        flush_model();
    endtask

    task automatic start_test(string name);
        cur_test = name;
        test_err_start = errors;
        tests++;
    endtask

    task automatic end_test();
        $display("test %s done, %0d errors", cur_test, errors - test_err_start);
    endtask

    // Output monitor sampling mid-cycle
    always @(negedge clk) begin : monitor
        int n;
        int tu;
        int tv;
        masked_share_pkg::masked_coeff_t eu;
        masked_share_pkg::masked_coeff_t ev;
        if (reset_n) begin
            // Busy from the cycle after issue until the output cycle
            check_value({cur_test, " busy_o"},
                        int'(issue_cyc_q.size() > 0 && issue_cyc_q[0] < cyc), int'(busy));
            if (valid_out) begin
                if (issue_cyc_q.size() == 0) begin
                    report_error("valid_o went high with no item in flight");
                end
                else begin
                    n = issue_cyc_q.pop_front();
                    eu = exp_u_q.pop_front();
                    ev = exp_v_q.pop_front();
                    tu = true_u_q.pop_front();
                    tv = true_v_q.pop_front();
                    check_value({cur_test, " latency"}, n + LAT, cyc);
                    check_value({cur_test, " u_o.share0"}, eu.share0, u_out.share0);
                    check_value({cur_test, " u_o.share1"}, eu.share1, u_out.share1);
                    check_value({cur_test, " v_o.share0"}, ev.share0, v_out.share0);
                    check_value({cur_test, " v_o.share1"}, ev.share1, v_out.share1);
                    // Unmasked results
                    check_value({cur_test, " u_o sum"}, tu,
                                (int'(u_out.share0) + int'(u_out.share1)) % Q);
                    check_value({cur_test, " v_o sum"}, tv,
                                (int'(v_out.share0) + int'(v_out.share1)) % Q);
                    // Shares stay reduced
                    check_value({cur_test, " u_o.share0 below q"}, 1, int'(u_out.share0 < Q));
                    check_value({cur_test, " u_o.share1 below q"}, 1, int'(u_out.share1 < Q));
                    check_value({cur_test, " v_o.share0 below q"}, 1, int'(v_out.share0 < Q));
                    check_value({cur_test, " v_o.share1 below q"}, 1, int'(v_out.share1 < Q));
                end
            end
            else if (issue_cyc_q.size() > 0 && issue_cyc_q[0] + LAT <= cyc) begin
                report_error($sformatf("valid_o missing for item issued in cycle %0d",
                                       issue_cyc_q[0]));
                drop_oldest();
            end
            if (zero_chk) begin
                check_value({cur_test, " valid_o cleared"}, 0, int'(valid_out));
                check_value({cur_test, " busy_o cleared"}, 0, int'(busy));
                check_value({cur_test, " u_o cleared"}, 0, int'(u_out));
                check_value({cur_test, " v_o cleared"}, 0, int'(v_out));
            end
        end
    end

    // Run limit from the test lengths
    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("Watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'he964));
        reset_n = 1'b0;
        zeroize = 1'b0;
        valid_in = 1'b0;
        opu = '0;
        opv = '0;
        opw = '0;
        rnd = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset_n = 1'b1;

        start_test("reset");
        zero_chk = 1'b1;
        idle_cycles(3);
        zero_chk = 1'b0;
        end_test();

        // One item at a time
        start_test("single");
        for (int i = 0; i < N_SINGLE; i++) begin
            issue_item();
            wait_drained();
        end
        end_test();

        // Back-to-back runs broken by short gaps
        start_test("stream");
        for (int i = 0; i < N_STREAM; i++) begin
            issue_item();
            if ($urandom % 3 == 0) begin
                idle_cycles(1 + $urandom % 3);
            end
        end
        wait_drained();
        end_test();

        start_test("zeroize");
        for (int i = 0; i < N_ZERO_PRE; i++) begin
            issue_item();
            if ($urandom % 4 == 0) begin
                idle_cycles(1);
            end
        end
        apply_zeroize();
        zero_chk = 1'b1;
        idle_cycles(LAT + 1);
        zero_chk = 1'b0;
        // Pipeline must work normally again
        for (int i = 0; i < N_ZERO_POST; i++) begin
            issue_item();
        end
        wait_drained();
        end_test();

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end
        else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
